//--- rv32i_pkg.sv
// Shared RV32I types and constants; imported by every module of the execute core
`default_nettype none

package rv32i_pkg;

  localparam int XLEN   = 32;
  localparam int NREGS  = 32;
  localparam int REG_AW = 5;

  // SYSTEM encoding treated as a stop request
  localparam logic [XLEN-1:0] HALT_INSTR = 32'h7800d073;

  typedef enum logic [6:0] {
    REGREG = 7'b0110011,
    IMMED  = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // Shared by OP and OP-IMM
  typedef enum logic [2:0] {
    ADDSUB = 3'd0,
    SLL    = 3'd1,
    SLT    = 3'd2,
    SLTU   = 3'd3,
    XOR    = 3'd4,
    SR     = 3'd5,
    OR     = 3'd6,
    AND    = 3'd7
  } alu_f3_e;

  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd4,
    BGE  = 3'd5,
    BLTU = 3'd6,
    BGEU = 3'd7
  } branch_e;

  // Stores reuse LB/LH/LW for SB/SH/SW
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd4,
    LHU = 3'd5
  } load_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } alu_op_e;

  // Operand source for alu_a and alu_b
  typedef enum logic [1:0] {SEL_REG, SEL_PC, SEL_IMM} opsel_e;

  // Write-back source
  typedef enum logic [1:0] {W_ALU, W_PC4, W_IMM} wsel_e;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    opcode_e           opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0]       imm11_00;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    opcode_e           opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0]        imm11_05;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [4:0]        imm04_00;
    opcode_e           opcode;
  } stype_t;

  typedef struct packed {
    logic              imm12;
    logic [5:0]        imm10_05;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [3:0]        imm04_01;
    logic              imm11;
    opcode_e           opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0]       imm31_12;
    logic [REG_AW-1:0] rd;
    opcode_e           opcode;
  } utype_t;

  typedef struct packed {
    logic              imm20;
    logic [9:0]        imm10_01;
    logic              imm11;
    logic [7:0]        imm19_12;
    logic [REG_AW-1:0] rd;
    opcode_e           opcode;
  } ujtype_t;

  typedef union packed {
    rtype_t          r;
    itype_t          i;
    stype_t          s;
    sbtype_t         sb;
    utype_t          u;
    ujtype_t         uj;
    logic [XLEN-1:0] raw;
  } instr_u;

  typedef struct packed {
    logic              valid;
    opcode_e           opcode;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm;
    alu_op_e           alu_op;
    opsel_e            alu_a_sel;
    opsel_e            alu_b_sel;
    wsel_e             w_sel;
    logic              wen;
    logic              dren;
    logic              dwen;
    logic              branch;
    logic              jump;
    logic              j_sel;
    logic [2:0]        funct3;
    logic              halt;
    logic [XLEN-1:0]   pc;
  } decode_t;

  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] rd;
    alu_op_e           alu_op;
    wsel_e             w_sel;
    logic              wen;
    logic              dren;
    logic              dwen;
    logic              branch;
    logic              jump;
    logic              j_sel;
    logic [2:0]        funct3;
    logic              halt;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   alu_a;
    logic [XLEN-1:0]   alu_b;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc;
  } operand_t;

  typedef struct packed {
    logic              valid;
    logic              wen;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   data;
  } wb_t;

  typedef struct packed {
    logic            dren;
    logic            dwen;
    logic [XLEN-1:0] addr;
    logic [3:0]      byte_en;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

//--- alu.sv
// Combinational RV32I ALU used by the execute stage
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  rv32i_pkg::alu_op_e          op_i,
  input  logic [rv32i_pkg::XLEN-1:0]  a_i,
  input  logic [rv32i_pkg::XLEN-1:0]  b_i,
  output logic [rv32i_pkg::XLEN-1:0]  res_o
);
  import rv32i_pkg::*;

  logic [4:0] shamt;

  // Only the low five bits shift
  assign shamt = b_i[4:0];

  always_comb begin
    unique case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = $signed(a_i) >>> shamt;
      ALU_AND:  res_o = a_i & b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SLT:  res_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: res_o = {31'b0, a_i < b_i};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- control_unit.sv
// Combinational RV32I decoder; turns the fetched word and its PC into decode control
`timescale 1ns/10ps
`default_nettype none

module control_unit (
  input  rv32i_pkg::instr_u              instr_i,
  input  logic [rv32i_pkg::XLEN-1:0]     pc_i,
  input  logic                           valid_i,
  output rv32i_pkg::decode_t             dec_o
);
  import rv32i_pkg::*;

  opcode_e         op;
  alu_f3_e         f3;
  logic            is_shift_imm;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_sb;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_uj;
  alu_op_e         alu_op;

  assign op = instr_i.r.opcode;
  assign f3 = alu_f3_e'(instr_i.r.funct3);

  // Sign-extended immediates for each format
  assign imm_i  = {{20{instr_i.i.imm11_00[11]}}, instr_i.i.imm11_00};
  assign imm_s  = {{20{instr_i.s.imm11_05[6]}}, instr_i.s.imm11_05, instr_i.s.imm04_00};
  assign imm_sb = {{19{instr_i.sb.imm12}}, instr_i.sb.imm12, instr_i.sb.imm11,
                   instr_i.sb.imm10_05, instr_i.sb.imm04_01, 1'b0};
  assign imm_u  = {instr_i.u.imm31_12, 12'b0};
  assign imm_uj = {{11{instr_i.uj.imm20}}, instr_i.uj.imm20, instr_i.uj.imm19_12,
                   instr_i.uj.imm11, instr_i.uj.imm10_01, 1'b0};

  // SRAI carries funct7 in the immediate, so shifts take only the shamt
  assign is_shift_imm = (op == IMMED) && (f3 == SLL || f3 == SR);

  // Bit 30 splits ADD/SUB and SRL/SRA
  always_comb begin
    alu_op = ALU_ADD;
    if (op == REGREG || op == IMMED) begin
      unique case (f3)
        ADDSUB: alu_op = (op == REGREG && instr_i.r.funct7[5]) ? ALU_SUB : ALU_ADD;
        SLL:    alu_op = ALU_SLL;
        SLT:    alu_op = ALU_SLT;
        SLTU:   alu_op = ALU_SLTU;
        XOR:    alu_op = ALU_XOR;
        SR:     alu_op = instr_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
        OR:     alu_op = ALU_OR;
        AND:    alu_op = ALU_AND;
      endcase
    end
  end

  always_comb begin
    dec_o        = '0;
    dec_o.valid  = valid_i;
    dec_o.opcode = op;
    dec_o.rs1    = instr_i.r.rs1;
    dec_o.rs2    = instr_i.r.rs2;
    dec_o.rd     = instr_i.r.rd;
    dec_o.alu_op = alu_op;
    dec_o.funct3 = instr_i.r.funct3;
    dec_o.dren   = (op == LOAD);
    dec_o.dwen   = (op == STORE);
    dec_o.branch = (op == BRANCH);
    dec_o.jump   = (op == JAL) || (op == JALR);
    dec_o.j_sel  = (op == JAL);
    dec_o.halt   = (instr_i.raw == HALT_INSTR);
    dec_o.pc     = pc_i;

    // Register + immediate is the common case
    dec_o.alu_a_sel = SEL_REG;
    dec_o.alu_b_sel = SEL_IMM;
    dec_o.w_sel     = W_ALU;

    case (op)
      REGREG: begin
        dec_o.alu_b_sel = SEL_REG;
        dec_o.wen       = 1'b1;
      end
      IMMED: begin
        dec_o.imm = is_shift_imm ? {27'b0, instr_i.r.rs2} : imm_i;
        dec_o.wen = 1'b1;
      end
      LOAD:  dec_o.imm = imm_i;
      STORE: dec_o.imm = imm_s;
      BRANCH: begin
        dec_o.imm       = imm_sb;
        dec_o.alu_b_sel = SEL_REG;
      end
      LUI: begin
        dec_o.imm   = imm_u;
        dec_o.w_sel = W_IMM;
        dec_o.wen   = 1'b1;
      end
      AUIPC: begin
        dec_o.imm       = imm_u;
        dec_o.alu_a_sel = SEL_PC;
        dec_o.wen       = 1'b1;
      end
      JAL: begin
        dec_o.imm   = imm_uj;
        dec_o.w_sel = W_PC4;
        dec_o.wen   = 1'b1;
      end
      JALR: begin
        dec_o.imm   = imm_i;
        dec_o.w_sel = W_PC4;
        dec_o.wen   = 1'b1;
      end
      // Unknown opcodes keep wen low and raise no request
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- operand_stage.sv
// Decode register, register-file read with forwarding and operand select; two register stages
`timescale 1ns/10ps
`default_nettype none

module operand_stage (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  rv32i_pkg::decode_t             dec_i,
  output logic [rv32i_pkg::REG_AW-1:0]   rs1_addr_o,
  output logic [rv32i_pkg::REG_AW-1:0]   rs2_addr_o,
  input  logic [rv32i_pkg::XLEN-1:0]     rs1_data_i,
  input  logic [rv32i_pkg::XLEN-1:0]     rs2_data_i,
  input  rv32i_pkg::wb_t                 ex_fwd_i,
  input  rv32i_pkg::wb_t                 wb_fwd_i,
  output rv32i_pkg::operand_t            op_o
);
  import rv32i_pkg::*;

  decode_t         dec_q;
  operand_t        op_d;
  logic [XLEN-1:0] rs1_fwd;
  logic [XLEN-1:0] rs2_fwd;

  // Execute result wins over the one being written back
  function automatic logic [XLEN-1:0] fwd_value(input logic [REG_AW-1:0] addr,
                                                input logic [XLEN-1:0]   rf_val,
                                                input wb_t               ex,
                                                input wb_t               wb);
    if (addr != '0 && ex.valid && ex.wen && ex.rd == addr) return ex.data;
    if (addr != '0 && wb.valid && wb.wen && wb.rd == addr) return wb.data;
    return rf_val;
  endfunction

  function automatic logic [XLEN-1:0] sel_operand(input opsel_e          sel,
                                                  input logic [XLEN-1:0] reg_val,
                                                  input logic [XLEN-1:0] pc,
                                                  input logic [XLEN-1:0] imm);
    case (sel)
      SEL_PC:  return pc;
      SEL_IMM: return imm;
      default: return reg_val;
    endcase
  endfunction

  always_ff @(posedge clk_i) begin
    dec_q <= dec_i;
    if (rst_i) begin
      dec_q.valid <= 1'b0;
    end
  end

  assign rs1_addr_o = dec_q.rs1;
  assign rs2_addr_o = dec_q.rs2;

  assign rs1_fwd = fwd_value(dec_q.rs1, rs1_data_i, ex_fwd_i, wb_fwd_i);
  assign rs2_fwd = fwd_value(dec_q.rs2, rs2_data_i, ex_fwd_i, wb_fwd_i);

  always_comb begin
    op_d.valid   = dec_q.valid;
    op_d.rd      = dec_q.rd;
    op_d.alu_op  = dec_q.alu_op;
    op_d.w_sel   = dec_q.w_sel;
    op_d.wen     = dec_q.wen;
    op_d.dren    = dec_q.dren;
    op_d.dwen    = dec_q.dwen;
    op_d.branch  = dec_q.branch;
    op_d.jump    = dec_q.jump;
    op_d.j_sel   = dec_q.j_sel;
    op_d.funct3  = dec_q.funct3;
    op_d.halt    = dec_q.halt;
    op_d.rs1_val = rs1_fwd;
    op_d.rs2_val = rs2_fwd;
    op_d.alu_a   = sel_operand(dec_q.alu_a_sel, rs1_fwd, dec_q.pc, dec_q.imm);
    op_d.alu_b   = sel_operand(dec_q.alu_b_sel, rs2_fwd, dec_q.pc, dec_q.imm);
    op_d.imm     = dec_q.imm;
    op_d.pc      = dec_q.pc;
  end

  always_ff @(posedge clk_i) begin
    op_o <= op_d;
    if (rst_i) begin
      op_o.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
// Execute stage: ALU, branch resolve, memory request and the registered core outputs
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  rv32i_pkg::operand_t   op_i,
  output rv32i_pkg::wb_t        ex_fwd_o,
  output rv32i_pkg::wb_t        wb_o,
  output rv32i_pkg::mem_req_t   mem_req_o,
  output rv32i_pkg::redirect_t  redirect_o,
  output logic                  halt_o
);
  import rv32i_pkg::*;

  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] wdata;
  logic [XLEN-1:0] tgt_sum;
  logic [3:0]      byte_en;
  logic            is_jalr;
  logic            cond;
  logic            live;

  alu u_alu (
    .op_i  (op_i.alu_op),
    .a_i   (op_i.alu_a),
    .b_i   (op_i.alu_b),
    .res_o (alu_res)
  );

  // Nothing after a captured halt is allowed out
  assign live = op_i.valid && !halt_o;

  always_comb begin
    case (op_i.w_sel)
      W_PC4:   wdata = op_i.pc + 32'd4;
      W_IMM:   wdata = op_i.imm;
      default: wdata = alu_res;
    endcase
  end

  always_comb begin
    case (branch_e'(op_i.funct3))
      BEQ:     cond = (op_i.rs1_val == op_i.rs2_val);
      BNE:     cond = (op_i.rs1_val != op_i.rs2_val);
      BLT:     cond = ($signed(op_i.rs1_val) < $signed(op_i.rs2_val));
      BGE:     cond = ($signed(op_i.rs1_val) >= $signed(op_i.rs2_val));
      BLTU:    cond = (op_i.rs1_val < op_i.rs2_val);
      BGEU:    cond = (op_i.rs1_val >= op_i.rs2_val);
      default: cond = 1'b0;
    endcase
  end

  // JALR adds to rs1 and drops bit 0, branches and JAL add to pc
  assign is_jalr = op_i.jump && !op_i.j_sel;
  assign tgt_sum = (is_jalr ? op_i.rs1_val : op_i.pc) + op_i.imm;

  // Lanes from the low address bits
  always_comb begin
    case (load_e'(op_i.funct3))
      LB, LBU: byte_en = 4'b0001 << alu_res[1:0];
      LH, LHU: begin
        case (alu_res[1:0])
          2'b00:   byte_en = 4'b0011;
          2'b10:   byte_en = 4'b1100;
          default: byte_en = 4'b0000;
        endcase
      end
      LW:      byte_en = 4'b1111;
      default: byte_en = 4'b0000;
    endcase
  end

  assign ex_fwd_o.valid = live;
  assign ex_fwd_o.wen   = op_i.wen;
  assign ex_fwd_o.rd    = op_i.rd;
  assign ex_fwd_o.data  = wdata;

  always_ff @(posedge clk_i) begin
    wb_o.valid         <= live;
    wb_o.wen           <= op_i.wen;
    wb_o.rd            <= op_i.rd;
    wb_o.data          <= wdata;
    mem_req_o.dren     <= live && op_i.dren;
    mem_req_o.dwen     <= live && op_i.dwen;
    mem_req_o.addr     <= alu_res;
    mem_req_o.byte_en  <= byte_en;
    mem_req_o.wdata    <= op_i.rs2_val;
    redirect_o.taken   <= live && ((op_i.branch && cond) || op_i.jump);
    redirect_o.target  <= {tgt_sum[XLEN-1:1], tgt_sum[0] && !is_jalr};
    if (rst_i) begin
      wb_o.valid       <= 1'b0;
      mem_req_o.dren   <= 1'b0;
      mem_req_o.dwen   <= 1'b0;
      redirect_o.taken <= 1'b0;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      halt_o <= 1'b0;
    end else if (live && op_i.halt) begin
      halt_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- reg_file.sv
// Integer register file; written from the write-back port, read asynchronously
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  rv32i_pkg::wb_t                wb_i,
  input  logic [rv32i_pkg::REG_AW-1:0]  rs1_addr_i,
  input  logic [rv32i_pkg::REG_AW-1:0]  rs2_addr_i,
  output logic [rv32i_pkg::XLEN-1:0]    rs1_data_o,
  output logic [rv32i_pkg::XLEN-1:0]    rs2_data_o
);
  import rv32i_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:NREGS-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.wen && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- rv32i_exec_core.sv
// Top of the three-stage RV32I execute core; instruction in, results out three edges later
`timescale 1ns/10ps
`default_nettype none

module rv32i_exec_core (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          instr_valid_i,
  input  logic [rv32i_pkg::XLEN-1:0]    instr_i,
  input  logic [rv32i_pkg::XLEN-1:0]    pc_i,
  output rv32i_pkg::wb_t                wb_o,
  output rv32i_pkg::mem_req_t           mem_req_o,
  output rv32i_pkg::redirect_t          redirect_o,
  output logic                          halt_o
);
  import rv32i_pkg::*;

  decode_t           dec;
  operand_t          op;
  wb_t               ex_fwd;
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;

  control_unit u_control_unit (
    .instr_i (instr_i),
    .pc_i    (pc_i),
    .valid_i (instr_valid_i),
    .dec_o   (dec)
  );

  operand_stage u_operand_stage (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .dec_i      (dec),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .ex_fwd_i   (ex_fwd),
    .wb_fwd_i   (wb_o),
    .op_o       (op)
  );

  execute_stage u_execute_stage (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .op_i       (op),
    .ex_fwd_o   (ex_fwd),
    .wb_o       (wb_o),
    .mem_req_o  (mem_req_o),
    .redirect_o (redirect_o),
    .halt_o     (halt_o)
  );

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_i       (wb_o),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Testbench clock and reset source; 8 ns clock, reset held for the first four cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #4 clk_o = ~clk_o;
    end
  end

  // Release on a falling edge like every other input
  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- rv32i_exec_assert.sv
// Concurrent properties on the execute stage outputs; attached to execute_stage by bind
`timescale 1ns/10ps
`default_nettype none

module rv32i_exec_assert (
  input logic                 clk_i,
  input logic                 rst_i,
  input rv32i_pkg::wb_t       wb_o,
  input rv32i_pkg::mem_req_t  mem_req_o,
  input rv32i_pkg::redirect_t redirect_o,
  input logic                 halt_o
);

  int unsigned fail_cnt = 0;

  // Every output strobe is low in the cycle after a reset edge
  idle_after_reset: assert property (@(posedge clk_i)
    rst_i |=> (!wb_o.valid && !mem_req_o.dren && !mem_req_o.dwen &&
               !redirect_o.taken && !halt_o))
    else begin
      fail_cnt++;
      $error("outputs active after reset");
    end

  // Halt is sticky until reset
  halt_sticky: assert property (@(posedge clk_i)
    (halt_o && !rst_i) |=> halt_o)
    else begin
      fail_cnt++;
      $error("halt_o fell without reset");
    end

  one_mem_op: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mem_req_o.dren && mem_req_o.dwen))
    else begin
      fail_cnt++;
      $error("dren and dwen set together");
    end

endmodule

`default_nettype wire

//--- rv32i_exec_checker.sv
// Reference ISA model and output comparison for the execute core testbench
`timescale 1ns/10ps
`default_nettype none

module rv32i_exec_checker (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 instr_valid_i,
  input logic [31:0]          instr_i,
  input logic [31:0]          pc_i,
  input logic [2:0]           test_i,
  input rv32i_pkg::wb_t       wb_i,
  input rv32i_pkg::mem_req_t  mem_req_i,
  input rv32i_pkg::redirect_t redirect_i,
  input logic                 halt_i
);
  import rv32i_pkg::*;

  typedef struct {
    logic [2:0] test;
    wb_t        wb;
    mem_req_t   mem;
    redirect_t  redir;
    logic       halt;
  } exp_t;

  exp_t        q[$];
  exp_t        cur;
  logic [31:0] xr [32];
  logic        halted;
  int          chk [6];
  int          err [6];
  int          chk_total;
  int          err_total;
  string       names [6] = '{"alu_ops", "forwarding", "upper_jump",
                             "branches", "load_store", "halt"};

  initial begin
    chk_total = 0;
    err_total = 0;
    for (int i = 0; i < 6; i++) begin
      chk[i] = 0;
      err[i] = 0;
    end
  end

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Byte lanes per access size and offset
  function automatic logic [3:0] lanes(input logic [2:0] f3, input logic [1:0] off);
    case (f3)
      3'd0, 3'd4: return 4'b0001 << off;
      3'd1, 3'd5: return (off == 2'd0) ? 4'b0011 : ((off == 2'd2) ? 4'b1100 : 4'b0000);
      3'd2:       return 4'b1111;
      default:    return 4'b0000;
    endcase
  endfunction

  task automatic predict(output exp_t e);
    logic [6:0]  op;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        cond;
    op    = instr_i[6:0];
    rd    = instr_i[11:7];
    f3    = instr_i[14:12];
    a     = xr[instr_i[19:15]];
    b     = xr[instr_i[24:20]];
    imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    e.test  = test_i;
    e.wb    = '0;
    e.mem   = '0;
    e.redir = '0;
    if (instr_valid_i && !halted) begin
      e.wb.valid = 1'b1;
      e.wb.rd    = rd;
      case (op)
        7'b0110011: begin
          e.wb.wen  = 1'b1;
          e.wb.data = alu_ref(f3, instr_i[30], a, b);
        end
        7'b0010011: begin
          e.wb.wen = 1'b1;
          // Only shifts read bit 30 in the immediate form
          e.wb.data = alu_ref(f3, instr_i[30] && f3 == 3'd5, a, imm_i);
        end
        7'b0110111: begin
          e.wb.wen  = 1'b1;
          e.wb.data = {instr_i[31:12], 12'b0};
        end
        7'b0010111: begin
          e.wb.wen  = 1'b1;
          e.wb.data = pc_i + {instr_i[31:12], 12'b0};
        end
        7'b1101111: begin
          e.wb.wen        = 1'b1;
          e.wb.data       = pc_i + 32'd4;
          e.redir.taken   = 1'b1;
          e.redir.target  = pc_i + imm_j;
        end
        7'b1100111: begin
          e.wb.wen        = 1'b1;
          e.wb.data       = pc_i + 32'd4;
          e.redir.taken   = 1'b1;
          e.redir.target  = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
          case (f3)
            3'd0:    cond = (a == b);
            3'd1:    cond = (a != b);
            3'd4:    cond = ($signed(a) < $signed(b));
            3'd5:    cond = ($signed(a) >= $signed(b));
            3'd6:    cond = (a < b);
            default: cond = (a >= b);
          endcase
          e.redir.taken  = cond;
          e.redir.target = pc_i + imm_b;
        end
        7'b0000011: begin
          e.mem.dren    = 1'b1;
          e.mem.addr    = a + imm_i;
          e.mem.byte_en = lanes(f3, e.mem.addr[1:0]);
        end
        7'b0100011: begin
          e.mem.dwen    = 1'b1;
          e.mem.addr    = a + imm_s;
          e.mem.byte_en = lanes(f3, e.mem.addr[1:0]);
          e.mem.wdata   = b;
        end
        default: ;
      endcase
      if (e.wb.wen && rd != 5'd0) begin
        xr[rd] = e.wb.data;
      end
      if (instr_i == 32'h7800d073) begin
        halted = 1'b1;
      end
    end
    e.halt = halted;
  endtask

  task automatic check(input logic [2:0] t, input string what,
                       input logic [31:0] exp, input logic [31:0] act);
    chk[t]++;
    chk_total++;
    if (exp !== act) begin
      err[t]++;
      err_total++;
      $display("mismatch test %s %s: expected %h, actual %h", names[t], what, exp, act);
    end
  endtask

  task automatic compare(input exp_t e);
    check(e.test, "wb.valid", 32'(e.wb.valid), 32'(wb_i.valid));
    if (e.wb.valid) begin
      check(e.test, "wb.wen", 32'(e.wb.wen), 32'(wb_i.wen));
    end
    if (e.wb.valid && e.wb.wen) begin
      check(e.test, "wb.rd", 32'(e.wb.rd), 32'(wb_i.rd));
      check(e.test, "wb.data", e.wb.data, wb_i.data);
    end
    check(e.test, "dren", 32'(e.mem.dren), 32'(mem_req_i.dren));
    check(e.test, "dwen", 32'(e.mem.dwen), 32'(mem_req_i.dwen));
    if (e.mem.dren || e.mem.dwen) begin
      check(e.test, "addr", e.mem.addr, mem_req_i.addr);
      check(e.test, "byte_en", 32'(e.mem.byte_en), 32'(mem_req_i.byte_en));
    end
    if (e.mem.dwen) begin
      check(e.test, "wdata", e.mem.wdata, mem_req_i.wdata);
    end
    check(e.test, "taken", 32'(e.redir.taken), 32'(redirect_i.taken));
    if (e.redir.taken) begin
      check(e.test, "target", e.redir.target, redirect_i.target);
    end
    check(e.test, "halt", 32'(e.halt), 32'(halt_i));
  endtask

  // Inputs are stable at the rising edge, one record per cycle
  always @(posedge clk_i) begin
    if (rst_i) begin
      q.delete();
      halted = 1'b0;
      for (int i = 0; i < 32; i++) begin
        xr[i] = 32'd0;
      end
    end else begin
      predict(cur);
      q.push_back(cur);
    end
  end

  // Outputs follow the third register edge, read mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i && q.size() == 3) begin
      compare(q.pop_front());
    end
  end

  task automatic end_test(input int t);
    $display("test %s: %0d checks, %0d errors", names[t], chk[t], err[t]);
  endtask

  task automatic summary();
    $display("total: %0d checks, %0d errors", chk_total, err_total);
  endtask

endmodule

`default_nettype wire

//--- rv32i_exec_tb.sv
// Testbench top for the RV32I execute core; random instruction streams in six tests
`timescale 1ns/10ps
`default_nettype none

module rv32i_exec_tb;
  import rv32i_pkg::*;

  localparam int N_PER_TEST = 300;
  localparam int N_TESTS    = 6;
  localparam int N_TOTAL    = N_PER_TEST * N_TESTS;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [2:0]  test_id;
  logic [31:0] seed;
  wb_t         wb;
  mem_req_t    mem_req;
  redirect_t   redirect;
  logic        halt;

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  rv32i_exec_core u_rv32i_exec_core (
    .clk_i         (clk),
    .rst_i         (rst),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .wb_o          (wb),
    .mem_req_o     (mem_req),
    .redirect_o    (redirect),
    .halt_o        (halt)
  );

  rv32i_exec_checker u_checker (
    .clk_i         (clk),
    .rst_i         (rst),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .test_i        (test_id),
    .wb_i          (wb),
    .mem_req_i     (mem_req),
    .redirect_i    (redirect),
    .halt_i        (halt)
  );

  bind execute_stage rv32i_exec_assert u_exec_assert (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_o       (wb_o),
    .mem_req_o  (mem_req_o),
    .redirect_o (redirect_o),
    .halt_o     (halt_o)
  );

  function automatic int unsigned rnd(input int unsigned n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    // Low LCG bits cycle quickly
    return (seed >> 8) % n;
  endfunction

  function automatic logic [4:0] pick_reg(input int unsigned n);
    return 5'(rnd(n));
  endfunction

  function automatic logic [31:0] gen_alu(input int unsigned nregs);
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    f3 = 3'(rnd(8));
    if (rnd(2) == 0) begin
      f7 = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00;
      return {f7, pick_reg(nregs), pick_reg(nregs), f3, pick_reg(nregs), REGREG};
    end
    imm = 12'(rnd(4096));
    if (f3 == 3'd1) begin
      imm[11:5] = 7'h00;
    end else if (f3 == 3'd5) begin
      imm[11:5] = (rnd(2) == 1) ? 7'h20 : 7'h00;
    end
    return {imm, pick_reg(nregs), f3, pick_reg(nregs), IMMED};
  endfunction

  function automatic logic [31:0] gen_upper();
    logic [19:0] u;
    u = 20'(rnd(32'h100000));
    case (rnd(4))
      0:       return {u, pick_reg(8), LUI};
      1:       return {u, pick_reg(8), AUIPC};
      2:       return {u, pick_reg(8), JAL};
      default: return {u[19:8], pick_reg(8), 3'd0, pick_reg(8), JALR};
    endcase
  endfunction

  function automatic logic [31:0] gen_branch();
    logic [2:0]  kinds [6];
    logic [12:0] off;
    kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    off   = 13'(rnd(8192));
    return {off[12], off[10:5], pick_reg(4), pick_reg(4), kinds[rnd(6)],
            off[4:1], off[11], BRANCH};
  endfunction

  function automatic logic [31:0] gen_mem();
    logic [2:0]  kinds [5];
    logic [11:0] off;
    kinds = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    off   = 12'(rnd(4096));
    if (rnd(2) == 0) begin
      return {off, pick_reg(8), kinds[rnd(5)], pick_reg(8), LOAD};
    end
    return {off[11:5], pick_reg(8), pick_reg(8), 3'(rnd(3)), off[4:0], STORE};
  endfunction

  function automatic logic [31:0] gen_instr(input int t, input int i);
    case (t)
      0:       return gen_alu(32);
      1:       return gen_alu(4);
      2:       return (rnd(2) == 0) ? gen_upper() : gen_alu(8);
      3:       return (rnd(2) == 0) ? gen_branch() : gen_alu(4);
      4:       return (rnd(3) == 0) ? gen_alu(8) : gen_mem();
      default: begin
        if (i == N_PER_TEST / 2) begin
          return HALT_INSTR;
        end
        return (rnd(2) == 0) ? gen_alu(8) : gen_mem();
      end
    endcase
  endfunction

  // Inputs change only on falling edges
  task automatic run_test(input int t);
    test_id = 3'(t);
    for (int i = 0; i < N_PER_TEST; i++) begin
      if (t != 1 && rnd(4) == 0) begin
        @(negedge clk);
        instr_valid = 1'b0;
      end
      @(negedge clk);
      instr_valid = 1'b1;
      instr       = gen_instr(t, i);
      pc          = pc + 32'd4;
    end
    @(negedge clk);
    instr_valid = 1'b0;
    repeat (6) @(negedge clk);
    u_checker.end_test(t);
  endtask

  initial begin
    instr_valid = 1'b0;
    instr       = 32'd0;
    pc          = 32'd0;
    test_id     = 3'd0;
    seed        = 32'hddb6;
    wait (!rst);
    @(negedge clk);
    pc = {20'(rnd(32'h100000)), 12'h000};
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    u_checker.summary();
    if (u_checker.err_total == 0 &&
        u_rv32i_exec_core.u_execute_stage.u_exec_assert.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Four clock periods per instruction covers the gaps
  initial begin
    int unsigned limit;
    limit = N_TOTAL * 8 * 4 + 2000;
    #(limit);
    $display("watchdog: the run did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rv32i_pkg.sv
alu.sv
control_unit.sv
operand_stage.sv
execute_stage.sv
reg_file.sv
rv32i_exec_core.sv
tb_clock_gen.sv
rv32i_exec_assert.sv
rv32i_exec_checker.sv
rv32i_exec_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -j 0
TOP       ?= rv32i_exec_tb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf $(OBJDIR)
